// ==== sources.f ====
+incdir+verification
source/me_pkg.sv
source/word_collector.sv
source/mont_mul.sv
source/exp_controller.sv
source/me_top.sv
verification/tb_me_top.sv

// ==== Makefile ====
# Verilator build and run of the modular exponentiation testbench

obj_dir/Vtb_me_top: sources.f $(wildcard source/*.sv) $(wildcard verification/*.sv) \
		$(wildcard verification/*.svh)
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_me_top -f sources.f

run: obj_dir/Vtb_me_top
	./obj_dir/Vtb_me_top | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== verification/tb_me_model.svh ====
`ifndef TB_ME_MODEL_SVH
`define TB_ME_MODEL_SVH

// --------------------
// reference model
// --------------------
// x^y mod MODULUS by plain square-and-multiply, top exponent bit first
function automatic logic [63:0] mod_pow(input logic [63:0] x, input logic [63:0] y);
    logic [63:0] m;
    logic [63:0] base;
    logic [63:0] acc;
    int          i;
    m    = 64'(MODULUS);
    base = x % m;
    acc  = 64'd1;
    // both factors stay below 2^32, so every product fits in 64 bits
    for (i = OP_W - 1; i >= 0; i--) begin
        acc = (acc * acc) % m;
        if (y[i]) begin
            acc = (acc * base) % m;
        end
    end
    return acc;
endfunction

// --------------------
// random source
// --------------------
// 16-bit galois lfsr, maximal length mask
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 16'hB400;
    end
    return next;
endfunction

// --------------------
// compare
// --------------------
task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
    if (got !== expected) begin
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
        error_count++;
    end
endtask

`endif

// ==== verification/tb_me_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_me_top;
    import me_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_OPS         = 62;
    localparam int MODE_PARALLEL   = 0;
    localparam int MODE_INTERLEAVE = 1;
    localparam int MODE_Y_FIRST    = 2;
    localparam int MODE_GAPS       = 3;
    // worst case multiplies per operation, plus collection and output
    localparam int OP_CYCLES  = (2 * OP_W + 2) * (OP_W + 3) + 8 * NUM_WORDS;
    localparam int TIME_LIMIT = 2 * NUM_OPS * OP_CYCLES * CLK_PERIOD;

    logic  clk;
    logic  rst_n;
    logic  start;
    word_t x_word;
    logic  x_valid;
    word_t y_word;
    logic  y_valid;
    word_t result_word;
    logic  result_valid;
    logic  busy;

    int          error_count;
    int          test_count;
    int          fail_count;
    int          results_seen;
    logic [15:0] lfsr_state;
    logic [63:0] expected_q[$];

    `include "tb_me_model.svh"

    me_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .x_word       (x_word),
        .x_valid      (x_valid),
        .y_word       (y_word),
        .y_valid      (y_valid),
        .result_word  (result_word),
        .result_valid (result_valid),
        .busy         (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(TIME_LIMIT);
        $display("run timed out waiting for a result");
        $display("Simulation FAILED");
        $finish;
    end

    // --------------------
    // result collector
    // --------------------
    // sampled on the falling edge, away from the DUT's updates
    initial begin : result_collector
        operand_t    got;
        int          words;
        logic [63:0] expected;
        forever begin
            @(negedge clk);
            if (result_valid) begin
                got   = '0;
                words = 0;
                while (result_valid) begin
                    if (words < NUM_WORDS) begin
                        got[words*WORD_W +: WORD_W] = result_word;
                    end
                    words++;
                    @(negedge clk);
                end
                if (words != NUM_WORDS) begin
                    $display("result burst had %0d words instead of %0d", words, NUM_WORDS);
                    error_count++;
                end
                if (expected_q.size() == 0) begin
                    $display("result words came out with no operation started");
                    error_count++;
                end else begin
                    expected = expected_q.pop_front();
                    check_value("result_word", 64'(got), expected);
                end
                results_seen++;
            end
        end
    end

    // --------------------
    // stimulus helpers
    // --------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_cycle(input logic xv, input word_t xw, input logic yv, input word_t yw);
        x_valid = xv;
        x_word  = xw;
        y_valid = yv;
        y_word  = yw;
        next_cycle();
    endtask

    task automatic send_words(input operand_t x, input operand_t y, input int mode,
                              input bit extra);
        int i;
        for (i = 0; i < NUM_WORDS; i++) begin
            case (mode)
                MODE_INTERLEAVE: begin
                    drive_cycle(1'b1, x[i*WORD_W +: WORD_W], 1'b0, '0);
                    drive_cycle(1'b0, '0, 1'b1, y[i*WORD_W +: WORD_W]);
                end
                MODE_Y_FIRST: drive_cycle(1'b0, '0, 1'b1, y[i*WORD_W +: WORD_W]);
                MODE_GAPS: begin
                    drive_cycle(1'b1, x[i*WORD_W +: WORD_W], 1'b0, '0);
                    drive_cycle(1'b0, '0, 1'b0, '0);
                    drive_cycle(1'b0, '0, 1'b1, y[i*WORD_W +: WORD_W]);
                end
                default: drive_cycle(1'b1, x[i*WORD_W +: WORD_W], 1'b1, y[i*WORD_W +: WORD_W]);
            endcase
        end
        if (mode == MODE_Y_FIRST) begin
            for (i = 0; i < NUM_WORDS; i++) begin
                drive_cycle(1'b1, x[i*WORD_W +: WORD_W], 1'b0, '0);
            end
        end
        // collectors are full here, these words must be dropped
        if (extra) begin
            drive_cycle(1'b1, 8'hA5, 1'b1, 8'h5A);
            drive_cycle(1'b1, 8'h3C, 1'b1, 8'hC3);
        end
        x_valid = 1'b0;
        y_valid = 1'b0;
    endtask

    task automatic take_bits(input int n, output operand_t value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[OP_W-2:0], lfsr_state[0]};
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            fail_count++;
            $display("test %0d %s: errors", test_count, name);
        end
    endtask

    task automatic launch_op(input operand_t x, input operand_t y, input int mode,
                             input bit extra, input bit poke_start);
        expected_q.push_back(mod_pow(64'(x), 64'(y)));
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        send_words(x, y, mode, extra);
        if (poke_start) begin
            repeat (8) next_cycle();
            check_value("busy", 64'(busy), 64'd1);
            // a second start and stray words mid-run
            start   = 1'b1;
            x_valid = 1'b1;
            x_word  = 8'hFF;
            y_valid = 1'b1;
            y_word  = 8'h77;
            next_cycle();
            start   = 1'b0;
            x_valid = 1'b0;
            y_valid = 1'b0;
        end
    endtask

    task automatic finish_op(input string name, input int errors_before, input int target);
        while (results_seen < target || busy) begin
            next_cycle();
        end
        report_test(name, errors_before);
    endtask

    task automatic run_op(input string name, input operand_t x, input operand_t y,
                          input int mode, input bit extra, input bit poke_start);
        int errors_before;
        int target;
        errors_before = error_count;
        target = results_seen + 1;
        launch_op(x, y, mode, extra, poke_start);
        finish_op(name, errors_before, target);
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        int       errors_before;
        int       target;
        int       i;
        operand_t rx;
        operand_t ry;
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        x_word       = '0;
        x_valid      = 1'b0;
        y_word       = '0;
        y_valid      = 1'b0;
        error_count  = 0;
        test_count   = 0;
        fail_count   = 0;
        results_seen = 0;
        lfsr_state   = 16'd16997;

        errors_before = error_count;
        repeat (2) next_cycle();
        check_value("result_valid", 64'(result_valid), 64'd0);
        check_value("busy", 64'(busy), 64'd0);
        next_cycle();
        rst_n = 1'b1;
        next_cycle();
        check_value("result_valid", 64'(result_valid), 64'd0);
        check_value("busy", 64'(busy), 64'd0);
        report_test("reset", errors_before);

        run_op("y zero", 32'h1234_5678, 32'h0, MODE_PARALLEL, 1'b0, 1'b0);
        run_op("y one", 32'h8765_4321, 32'h1, MODE_PARALLEL, 1'b0, 1'b0);
        run_op("y one with x above modulus", 32'hFFFF_FFFE, 32'h1, MODE_PARALLEL, 1'b0, 1'b0);
        run_op("x zero", 32'h0, 32'hDEAD_BEEF, MODE_PARALLEL, 1'b0, 1'b0);
        run_op("y all ones", 32'h0BAD_F00D, 32'hFFFF_FFFF, MODE_PARALLEL, 1'b0, 1'b0);

        for (i = 0; i < 50; i++) begin
            take_bits(OP_W, rx);
            take_bits(OP_W, ry);
            run_op($sformatf("random %0d", i), rx, ry, MODE_PARALLEL, 1'b0, 1'b0);
        end

        take_bits(OP_W, rx);
        take_bits(OP_W, ry);
        run_op("interleaved words", rx, ry, MODE_INTERLEAVE, 1'b0, 1'b0);
        run_op("x after y", ry, rx, MODE_Y_FIRST, 1'b0, 1'b0);
        run_op("gaps in valid", rx ^ ry, ry, MODE_GAPS, 1'b0, 1'b0);
        run_op("extra words", ry, rx ^ ry, MODE_PARALLEL, 1'b1, 1'b0);
        run_op("start while busy", rx, ry, MODE_PARALLEL, 1'b0, 1'b1);

        // second start lands on the first idle cycle after the last result word
        errors_before = error_count;
        target        = results_seen + 2;
        launch_op(ry, rx, MODE_PARALLEL, 1'b0, 1'b0);
        while (busy) begin
            next_cycle();
        end
        launch_op(rx ^ ry, rx, MODE_PARALLEL, 1'b0, 1'b0);
        finish_op("back to back", errors_before, target);

        $display("tests: %0d run, %0d ok, %0d with errors",
                 test_count, test_count - fail_count, fail_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/me_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module me_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  me_pkg::word_t x_word,
    input  logic          x_valid,
    input  me_pkg::word_t y_word,
    input  logic          y_valid,
    output me_pkg::word_t result_word,
    output logic          result_valid,
    output logic          busy
);
    import me_pkg::*;

    operand_t       x_value;
    operand_t       y_value;
    logic           x_full;
    logic           y_full;
    logic           collect_clear;
    logic           mont_req;
    logic           mont_ack;
    mont_operands_t mont_ops;
    operand_t       mont_result;

    // --------------------
    // operand collection
    // --------------------
    word_collector x_collector (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (collect_clear),
        .word  (x_word),
        .valid (x_valid),
        .value (x_value),
        .full  (x_full)
    );

    word_collector y_collector (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (collect_clear),
        .word  (y_word),
        .valid (y_valid),
        .value (y_value),
        .full  (y_full)
    );

    // --------------------
    // exponentiation core
    // --------------------
    exp_controller controller (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .x_full        (x_full),
        .y_full        (y_full),
        .x_value       (x_value),
        .y_value       (y_value),
        .mont_req      (mont_req),
        .mont_ops      (mont_ops),
        .mont_ack      (mont_ack),
        .mont_result   (mont_result),
        .collect_clear (collect_clear),
        .result_word   (result_word),
        .result_valid  (result_valid),
        .busy          (busy)
    );

    mont_mul multiplier (
        .clk         (clk),
        .rst_n       (rst_n),
        .mont_req    (mont_req),
        .mont_ops    (mont_ops),
        .mont_ack    (mont_ack),
        .mont_result (mont_result)
    );

endmodule

`default_nettype wire

// ==== source/exp_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module exp_controller (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   x_full,
    input  logic                   y_full,
    input  me_pkg::operand_t       x_value,
    input  me_pkg::operand_t       y_value,
    output logic                   mont_req,
    output me_pkg::mont_operands_t mont_ops,
    input  logic                   mont_ack,
    input  me_pkg::operand_t       mont_result,
    output logic                   collect_clear,
    output me_pkg::word_t          result_word,
    output logic                   result_valid,
    output logic                   busy
);
    import me_pkg::*;

    exp_state_t                  state_q;
    operand_t                    x_mont_q;
    operand_t                    res_q;
    operand_t                    exp_q;
    logic [$clog2(OP_W)-1:0]     bit_cnt_q;
    word_idx_t                   out_cnt_q;
    logic                        mul_state;
    logic                        mul_done;
    logic                        last_bit;

    assign mul_state = (state_q == ST_TO_DOMAIN) || (state_q == ST_SQUARE) ||
                       (state_q == ST_MULTIPLY)  || (state_q == ST_FROM_DOMAIN);
    assign mul_done  = mont_req && mont_ack;
    assign last_bit  = (int'(bit_cnt_q) == OP_W - 1);

    // --------------------
    // multiplier operands
    // --------------------
    // b always holds a value below the modulus
    always_comb begin
        mont_ops = '0;
        case (state_q)
            ST_TO_DOMAIN: begin
                mont_ops.a = x_value;
                mont_ops.b = R2_MOD_M;
            end
            ST_SQUARE: begin
                mont_ops.a = res_q;
                mont_ops.b = res_q;
            end
            ST_MULTIPLY: begin
                mont_ops.a = res_q;
                mont_ops.b = x_mont_q;
            end
            ST_FROM_DOMAIN: begin
                mont_ops.a = operand_t'(1);
                mont_ops.b = res_q;
            end
            default: mont_ops = '0;
        endcase
    end

    // --------------------
    // control fsm
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            mont_req  <= 1'b0;
            bit_cnt_q <= '0;
            out_cnt_q <= '0;
        end else begin
            // no new request until the previous ack is gone
            if (mul_state && !mont_req && !mont_ack) begin
                mont_req <= 1'b1;
            end else if (mul_done) begin
                mont_req <= 1'b0;
            end

            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_COLLECT;
                    end
                end
                ST_COLLECT: begin
                    if (x_full && y_full) begin
                        bit_cnt_q <= '0;
                        state_q   <= ST_TO_DOMAIN;
                    end
                end
                ST_TO_DOMAIN: begin
                    if (mul_done) begin
                        state_q <= ST_SQUARE;
                    end
                end
                ST_SQUARE: begin
                    if (mul_done) begin
                        if (exp_q[OP_W-1]) begin
                            state_q <= ST_MULTIPLY;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            state_q   <= last_bit ? ST_FROM_DOMAIN : ST_SQUARE;
                        end
                    end
                end
                ST_MULTIPLY: begin
                    if (mul_done) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        state_q   <= last_bit ? ST_FROM_DOMAIN : ST_SQUARE;
                    end
                end
                ST_FROM_DOMAIN: begin
                    if (mul_done) begin
                        out_cnt_q <= '0;
                        state_q   <= ST_OUTPUT;
                    end
                end
                ST_OUTPUT: begin
                    out_cnt_q <= out_cnt_q + 1'b1;
                    if (out_cnt_q == word_idx_t'(NUM_WORDS - 1)) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // working values, loaded along the fsm path
    always_ff @(posedge clk) begin
        case (state_q)
            ST_COLLECT: begin
                if (x_full && y_full) begin
                    exp_q <= y_value;
                    res_q <= R_MOD_M;
                end
            end
            ST_TO_DOMAIN: begin
                if (mul_done) begin
                    x_mont_q <= mont_result;
                end
            end
            ST_SQUARE: begin
                if (mul_done) begin
                    res_q <= mont_result;
                    // set bit keeps exp for the multiply step
                    if (!exp_q[OP_W-1]) begin
                        exp_q <= exp_q << 1;
                    end
                end
            end
            ST_MULTIPLY: begin
                if (mul_done) begin
                    res_q <= mont_result;
                    exp_q <= exp_q << 1;
                end
            end
            ST_FROM_DOMAIN: begin
                if (mul_done) begin
                    res_q <= mont_result;
                end
            end
            ST_OUTPUT: res_q <= res_q >> WORD_W;
            default: ;
        endcase
    end

    // low word first, one per cycle
    assign result_word   = res_q[WORD_W-1:0];
    assign result_valid  = (state_q == ST_OUTPUT);
    assign busy          = (state_q != ST_IDLE);
    assign collect_clear = (state_q == ST_IDLE) && start;

endmodule

`default_nettype wire

// ==== source/mont_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_mul (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mont_req,
    input  me_pkg::mont_operands_t mont_ops,
    output logic                   mont_ack,
    output me_pkg::operand_t       mont_result
);
    import me_pkg::*;

    operand_t                      a_q;
    operand_t                      b_q;
    logic [OP_W:0]                 acc_q;
    logic [$clog2(OP_W + 1)-1:0]   bit_cnt_q;
    logic                          running_q;
    logic                          launch;
    logic                          final_step;
    logic [OP_W+1:0]               sum_b;
    logic [OP_W+1:0]               sum_m;

    // a new request is only taken once the previous ack has dropped
    assign launch     = mont_req && !running_q && !mont_ack;
    assign final_step = running_q && (int'(bit_cnt_q) == OP_W);

    // --------------------
    // one radix-2 step
    // --------------------
    always_comb begin
        sum_b = {1'b0, acc_q} + (a_q[0] ? {2'b00, b_q} : '0);
        // make the sum even so the halving is exact
        sum_m = sum_b + (sum_b[0] ? {2'b00, MODULUS} : '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running_q <= 1'b0;
            mont_ack  <= 1'b0;
            bit_cnt_q <= '0;
        end else if (running_q) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (final_step) begin
                running_q <= 1'b0;
                mont_ack  <= 1'b1;
            end
        end else if (mont_ack) begin
            // four-phase return, wait for req to go away
            if (!mont_req) begin
                mont_ack <= 1'b0;
            end
        end else if (mont_req) begin
            running_q <= 1'b1;
            bit_cnt_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            a_q   <= mont_ops.a;
            b_q   <= mont_ops.b;
            acc_q <= '0;
        end else if (final_step) begin
            // acc is below 2m here, one subtraction is enough
            if (acc_q >= {1'b0, MODULUS}) begin
                acc_q <= acc_q - {1'b0, MODULUS};
            end
        end else if (running_q) begin
            acc_q <= sum_m[OP_W+1:1];
            a_q   <= a_q >> 1;
        end
    end

    assign mont_result = acc_q[OP_W-1:0];

endmodule

`default_nettype wire

// ==== source/word_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_collector (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  me_pkg::word_t    word,
    input  logic             valid,
    output me_pkg::operand_t value,
    output logic             full
);
    import me_pkg::*;

    operand_t  shift_q;
    word_idx_t count_q;
    logic      accept;

    // words past the operand size are dropped
    assign accept = valid && (count_q < word_idx_t'(NUM_WORDS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (clear) begin
            count_q <= '0;
        end else if (accept) begin
            count_q <= count_q + 1'b1;
        end
    end

    // new word enters at the top, first word ends up lowest
    always_ff @(posedge clk) begin
        if (accept && !clear) begin
            shift_q <= {word, shift_q[OP_W-1:WORD_W]};
        end
    end

    assign value = shift_q;
    assign full  = (count_q == word_idx_t'(NUM_WORDS));

endmodule

`default_nettype wire

// ==== source/me_pkg.sv ====
`default_nettype none

package me_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int WORD_W    = 8;
    localparam int NUM_WORDS = 4;
    localparam int OP_W      = WORD_W * NUM_WORDS;

    typedef logic [WORD_W-1:0]                  word_t;
    typedef logic [OP_W-1:0]                    operand_t;
    typedef logic [$clog2(NUM_WORDS + 1)-1:0]   word_idx_t;

    // --------------------
    // modulus and montgomery constants
    // --------------------
    // prime 2^32 - 5, odd as the radix-2 reduction needs
    localparam operand_t MODULUS  = 32'hFFFF_FFFB;
    // R = 2^OP_W, so R mod m is the montgomery form of one
    localparam operand_t R_MOD_M  = 32'd5;
    localparam operand_t R2_MOD_M = 32'd25;

    // multiplier operand pair, a is scanned bit by bit
    typedef struct packed {
        operand_t a;
        operand_t b;
    } mont_operands_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_TO_DOMAIN,
        ST_SQUARE,
        ST_MULTIPLY,
        ST_FROM_DOMAIN,
        ST_OUTPUT
    } exp_state_t;

endpackage

`default_nettype wire
